//--- addr_chan_gen.sv
// One AXI address channel (AW or AR), holds the beat registers and drives valid and done
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module addr_chan_gen
#(
   parameter logic [`CFG_OFS_WIDTH-1:0] BASE = `AW_BASE
)
(
   input  logic                    clk,
   input  logic                    sync_rst_n,
   input  axi_tst_pkg::cfg_req_t   cfg_req,
   output axi_tst_pkg::addr_beat_t beat,
   output logic                    valid,
   input  logic                    ready,
   output logic                    done
);

   logic ctrl_wr;
   logic lo_wr;
   logic hi_wr;
   logic len_id_wr;
   logic handshake;

   assign ctrl_wr   = cfg_req.wr && (cfg_req.ofs == BASE + `REG_CTRL);
   assign lo_wr     = cfg_req.wr && (cfg_req.ofs == BASE + `REG_ADDR_LO);
   assign hi_wr     = cfg_req.wr && (cfg_req.ofs == BASE + `REG_ADDR_HI);
   assign len_id_wr = cfg_req.wr && (cfg_req.ofs == BASE + `REG_LEN_ID);
   assign handshake = valid && ready;

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         beat <= '0;
      else
      begin
         if (lo_wr)
            beat.addr[31:0] <= cfg_req.wdata;
         if (hi_wr)
            beat.addr[`AXI_ADDR_WIDTH-1:32] <= cfg_req.wdata;
         // Length in the low byte, ID packed right above it
         if (len_id_wr)
         begin
            beat.len <= cfg_req.wdata[`AXI_LEN_WIDTH-1:0];
            beat.id  <= cfg_req.wdata[`AXI_LEN_WIDTH +: `AXI_ID_WIDTH];
         end
      end
   end

   // Valid holds until accepted, done is sticky until cleared by the host
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         valid <= 1'b0;
         done  <= 1'b0;
      end
      else
      begin
         if (ctrl_wr && cfg_req.wdata[`CTRL_SET_BIT])
            valid <= 1'b1;
         else if (handshake)
            valid <= 1'b0;
         if (handshake)
            done <= 1'b1;
         else if (ctrl_wr && cfg_req.wdata[`CTRL_CLR_BIT])
            done <= 1'b0;
      end
   end

endmodule

//--- axi_tst_assert.sv
// Protocol checks on the host port and AXI channels, bound to the generator top by the testbench
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module axi_tst_assert
(
   input logic                         clk,
   input logic                         sync_rst_n,
   input logic                         cfg_wr,
   input logic                         cfg_rd,
   input logic                         tst_cfg_ack,
   input logic [`AXI_ID_WIDTH-1:0]     awid,
   input logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
   input logic [`AXI_LEN_WIDTH-1:0]    awlen,
   input logic                         awvalid,
   input logic                         awready,
   input logic [`AXI_DATA_WIDTH-1:0]   wdata,
   input logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
   input logic                         wlast,
   input logic                         wvalid,
   input logic                         wready,
   input logic                         bvalid,
   input logic                         bready,
   input logic [`AXI_ID_WIDTH-1:0]     arid,
   input logic [`AXI_ADDR_WIDTH-1:0]   araddr,
   input logic [`AXI_LEN_WIDTH-1:0]    arlen,
   input logic                         arvalid,
   input logic                         arready
);

   // Commands are single pulses, so ack mirrors them three samples later
   ack_delay: assert property (@(posedge clk) disable iff (!sync_rst_n)
      tst_cfg_ack == $past(cfg_wr || cfg_rd, 3))
      else $error("tst_cfg_ack not exactly three cycles after a host command");
   ack_single: assert property (@(posedge clk) disable iff (!sync_rst_n)
      tst_cfg_ack |=> !tst_cfg_ack)
      else $error("tst_cfg_ack high for more than one cycle");

   aw_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      awvalid && !awready |=> awvalid && $stable({awaddr, awlen, awid}))
      else $error("awvalid or its beat changed before the handshake");
   aw_drop: assert property (@(posedge clk) disable iff (!sync_rst_n)
      awvalid && awready |=> !awvalid)
      else $error("awvalid still high after the handshake");

   w_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      wvalid && !wready |=> wvalid && $stable({wdata, wstrb, wlast}))
      else $error("wvalid or its beat changed before the handshake");
   w_drop: assert property (@(posedge clk) disable iff (!sync_rst_n)
      wvalid && wready |=> !wvalid)
      else $error("wvalid still high after the handshake");

   ar_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      arvalid && !arready |=> arvalid && $stable({araddr, arlen, arid}))
      else $error("arvalid or its beat changed before the handshake");
   ar_drop: assert property (@(posedge clk) disable iff (!sync_rst_n)
      arvalid && arready |=> !arvalid)
      else $error("arvalid still high after the handshake");

   b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      bready && !bvalid |=> bready)
      else $error("bready dropped before bvalid was seen");
   b_drop: assert property (@(posedge clk) disable iff (!sync_rst_n)
      bready && bvalid |=> !bready)
      else $error("bready still high after the B handshake");

   reset_idle: assert property (@(posedge clk)
      !sync_rst_n |=> !(awvalid || wvalid || arvalid || bready || tst_cfg_ack))
      else $error("valid, bready or ack high after reset");

endmodule

//--- axi_tst_config.svh
// Bus widths, register map offsets and readback constants for the AXI generator, include where needed
`ifndef AXI_TST_CONFIG_SVH
`define AXI_TST_CONFIG_SVH

`define AXI_DATA_WIDTH   128
`define AXI_NUM_DW       4
`define AXI_ADDR_WIDTH   64
`define AXI_ID_WIDTH     5
`define AXI_LEN_WIDTH    8

`define CFG_OFS_WIDTH    8
`define CFG_INDEX_WIDTH  16
`define CFG_UNIMPL_VALUE 32'hDEAD_DEAD

// Channel block bases
`define AW_BASE          8'h00
`define W_BASE           8'h20
`define B_BASE           8'h40
`define AR_BASE          8'h60

// Offsets inside a block
`define REG_CTRL         8'h0
`define REG_ADDR_LO      8'h4
`define REG_ADDR_HI      8'h8
`define REG_LEN_ID       8'hC
`define REG_W_INDEX      8'h4
`define REG_W_DATA       8'h8
`define REG_W_STRB       8'hC
`define REG_B_ID         8'h4

// Control register bits
`define CTRL_SET_BIT     0
`define CTRL_CLR_BIT     1
`define CTRL_WLAST_BIT   4

`endif

//--- axi_tst_pkg.sv
// Shared structs and enums of the AXI generator, referenced by scoped name from the RTL and testbench
`include "axi_tst_config.svh"

package axi_tst_pkg;

   // Address channels built by the generate loop in the top level
   typedef enum logic [0:0] {
      CHAN_AW = 1'b0,
      CHAN_AR = 1'b1
   } chan_sel_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // One-cycle request from the host front end
   typedef struct packed {
      logic                      wr;
      logic                      rd;
      logic [`CFG_OFS_WIDTH-1:0] ofs;
      logic [31:0]               wdata;
   } cfg_req_t;

   typedef struct packed {
      logic [`AXI_ADDR_WIDTH-1:0] addr;
      logic [`AXI_LEN_WIDTH-1:0]  len;
      logic [`AXI_ID_WIDTH-1:0]   id;
   } addr_beat_t;

   typedef struct packed {
      logic [`AXI_DATA_WIDTH-1:0]   data;
      logic [`AXI_DATA_WIDTH/8-1:0] strb;
      logic                         last;
   } wdata_beat_t;

   typedef struct packed {
      axi_resp_e                resp;
      logic [`AXI_ID_WIDTH-1:0] id;
   } bresp_t;

endpackage

//--- axi_tst_top.sv
// AXI master transaction generator top, host register port in and AW, W, B, AR channels out
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module axi_tst_top
(
   input  logic                         clk,
   input  logic                         sync_rst_n,

   input  logic [31:0]                  cfg_addr,
   input  logic [31:0]                  cfg_wdata,
   input  logic                         cfg_wr,
   input  logic                         cfg_rd,
   output logic                         tst_cfg_ack,
   output logic [31:0]                  tst_cfg_rdata,

   output logic [`AXI_ID_WIDTH-1:0]     awid,
   output logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
   output logic [`AXI_LEN_WIDTH-1:0]    awlen,
   output logic                         awvalid,
   input  logic                         awready,

   output logic [`AXI_DATA_WIDTH-1:0]   wdata,
   output logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
   output logic                         wlast,
   output logic                         wvalid,
   input  logic                         wready,

   input  logic [`AXI_ID_WIDTH-1:0]     bid,
   input  logic [1:0]                   bresp,
   input  logic                         bvalid,
   output logic                         bready,

   output logic [`AXI_ID_WIDTH-1:0]     arid,
   output logic [`AXI_ADDR_WIDTH-1:0]   araddr,
   output logic [`AXI_LEN_WIDTH-1:0]    arlen,
   output logic                         arvalid,
   input  logic                         arready
);

   axi_tst_pkg::cfg_req_t       cfg_req;
   axi_tst_pkg::addr_beat_t     addr_beat [2];
   logic [1:0]                  addr_valid;
   logic [1:0]                  addr_ready;
   logic [1:0]                  addr_done;
   axi_tst_pkg::wdata_beat_t    w_beat;
   logic                        w_done;
   logic [`CFG_INDEX_WIDTH-1:0] w_index;
   logic [31:0]                 w_index_word;
   logic                        b_done;
   axi_tst_pkg::bresp_t         b_captured;

   cfg_port u_cfg_port
   (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .cfg_wr      (cfg_wr),
      .cfg_rd      (cfg_rd),
      .cfg_req     (cfg_req),
      .tst_cfg_ack (tst_cfg_ack)
   );

   assign addr_ready[axi_tst_pkg::CHAN_AW] = awready;
   assign addr_ready[axi_tst_pkg::CHAN_AR] = arready;

   // AW and AR share one channel module, the enum picks the register block
   for (genvar gi = 0; gi <= int'(axi_tst_pkg::CHAN_AR); gi++)
   begin : g_addr_chan
      localparam axi_tst_pkg::chan_sel_e CHAN = axi_tst_pkg::chan_sel_e'(gi);

      addr_chan_gen
      #(
         .BASE ((CHAN == axi_tst_pkg::CHAN_AW) ? `AW_BASE : `AR_BASE)
      )
      u_addr_chan
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .cfg_req    (cfg_req),
         .beat       (addr_beat[CHAN]),
         .valid      (addr_valid[CHAN]),
         .ready      (addr_ready[CHAN]),
         .done       (addr_done[CHAN])
      );
   end

   assign awid    = addr_beat[axi_tst_pkg::CHAN_AW].id;
   assign awaddr  = addr_beat[axi_tst_pkg::CHAN_AW].addr;
   assign awlen   = addr_beat[axi_tst_pkg::CHAN_AW].len;
   assign awvalid = addr_valid[axi_tst_pkg::CHAN_AW];
   assign arid    = addr_beat[axi_tst_pkg::CHAN_AR].id;
   assign araddr  = addr_beat[axi_tst_pkg::CHAN_AR].addr;
   assign arlen   = addr_beat[axi_tst_pkg::CHAN_AR].len;
   assign arvalid = addr_valid[axi_tst_pkg::CHAN_AR];

   wdata_chan_gen u_wdata_chan
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg_req    (cfg_req),
      .beat       (w_beat),
      .valid      (wvalid),
      .ready      (wready),
      .done       (w_done),
      .index      (w_index),
      .index_word (w_index_word)
   );

   assign wdata = w_beat.data;
   assign wstrb = w_beat.strb;
   assign wlast = w_beat.last;

   bresp_capture u_bresp_capture
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg_req    (cfg_req),
      .bresp      (bresp),
      .bid        (bid),
      .bvalid     (bvalid),
      .bready     (bready),
      .done       (b_done),
      .captured   (b_captured)
   );

   cfg_readback u_cfg_readback
   (
      .clk           (clk),
      .sync_rst_n    (sync_rst_n),
      .cfg_req       (cfg_req),
      .aw_beat       (addr_beat[axi_tst_pkg::CHAN_AW]),
      .aw_valid      (addr_valid[axi_tst_pkg::CHAN_AW]),
      .aw_done       (addr_done[axi_tst_pkg::CHAN_AW]),
      .ar_beat       (addr_beat[axi_tst_pkg::CHAN_AR]),
      .ar_valid      (addr_valid[axi_tst_pkg::CHAN_AR]),
      .ar_done       (addr_done[axi_tst_pkg::CHAN_AR]),
      .w_beat        (w_beat),
      .w_valid       (wvalid),
      .w_done        (w_done),
      .w_index       (w_index),
      .w_index_word  (w_index_word),
      .b_ready       (bready),
      .b_done        (b_done),
      .b_captured    (b_captured),
      .tst_cfg_rdata (tst_cfg_rdata)
   );

endmodule

//--- bresp_capture.sv
// AXI B channel, drives bready on host request and captures the response and ID
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module bresp_capture
(
   input  logic                     clk,
   input  logic                     sync_rst_n,
   input  axi_tst_pkg::cfg_req_t    cfg_req,
   input  logic [1:0]               bresp,
   input  logic [`AXI_ID_WIDTH-1:0] bid,
   input  logic                     bvalid,
   output logic                     bready,
   output logic                     done,
   output axi_tst_pkg::bresp_t      captured
);

   logic ctrl_wr;
   logic handshake;

   assign ctrl_wr   = cfg_req.wr && (cfg_req.ofs == `B_BASE + `REG_CTRL);
   assign handshake = bvalid && bready;

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         bready   <= 1'b0;
         done     <= 1'b0;
         captured <= '0;
      end
      else
      begin
         if (ctrl_wr && cfg_req.wdata[`CTRL_SET_BIT])
            bready <= 1'b1;
         else if (handshake)
            bready <= 1'b0;
         if (handshake)
         begin
            done          <= 1'b1;
            captured.resp <= axi_tst_pkg::axi_resp_e'(bresp);
            captured.id   <= bid;
         end
         else if (ctrl_wr && cfg_req.wdata[`CTRL_CLR_BIT])
            done <= 1'b0;
      end
   end

endmodule

//--- cfg_port.sv
// Host register front end, turns each cfg_wr or cfg_rd pulse into one request cycle and an ack
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module cfg_port
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  logic [31:0]            cfg_addr,
   input  logic [31:0]            cfg_wdata,
   input  logic                   cfg_wr,
   input  logic                   cfg_rd,
   output axi_tst_pkg::cfg_req_t  cfg_req,
   output logic                   tst_cfg_ack
);

   logic                      pend_wr;
   logic                      pend_rd;
   logic                      req_wr;
   logic                      req_rd;
   logic [`CFG_OFS_WIDTH-1:0] ofs_q;
   logic [31:0]               wdata_q;

   // Command capture, then request, then ack, one stage each
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         pend_wr     <= 1'b0;
         pend_rd     <= 1'b0;
         req_wr      <= 1'b0;
         req_rd      <= 1'b0;
         tst_cfg_ack <= 1'b0;
      end
      else
      begin
         pend_wr     <= cfg_wr;
         pend_rd     <= cfg_rd;
         req_wr      <= pend_wr;
         req_rd      <= pend_rd;
         tst_cfg_ack <= req_wr || req_rd;
      end
   end

   // Only the low offset bits matter, the block is decoded upstream
   always_ff @(posedge clk)
   begin
      if (cfg_wr || cfg_rd)
      begin
         ofs_q   <= cfg_addr[`CFG_OFS_WIDTH-1:0];
         wdata_q <= cfg_wdata;
      end
   end

   assign cfg_req = '{wr: req_wr, rd: req_rd, ofs: ofs_q, wdata: wdata_q};

endmodule

//--- cfg_readback.sv
// Registered readback mux over all channel state, loaded on the internal read strobe
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module cfg_readback
(
   input  logic                        clk,
   input  logic                        sync_rst_n,
   input  axi_tst_pkg::cfg_req_t       cfg_req,
   input  axi_tst_pkg::addr_beat_t     aw_beat,
   input  logic                        aw_valid,
   input  logic                        aw_done,
   input  axi_tst_pkg::addr_beat_t     ar_beat,
   input  logic                        ar_valid,
   input  logic                        ar_done,
   input  axi_tst_pkg::wdata_beat_t    w_beat,
   input  logic                        w_valid,
   input  logic                        w_done,
   input  logic [`CFG_INDEX_WIDTH-1:0] w_index,
   input  logic [31:0]                 w_index_word,
   input  logic                        b_ready,
   input  logic                        b_done,
   input  axi_tst_pkg::bresp_t         b_captured,
   output logic [31:0]                 tst_cfg_rdata
);

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         tst_cfg_rdata <= '0;
      else if (cfg_req.rd)
      begin
         case (cfg_req.ofs)
            `AW_BASE + `REG_CTRL    : tst_cfg_rdata <= {30'd0, aw_done, aw_valid};
            `AW_BASE + `REG_ADDR_LO : tst_cfg_rdata <= aw_beat.addr[31:0];
            `AW_BASE + `REG_ADDR_HI : tst_cfg_rdata <= aw_beat.addr[`AXI_ADDR_WIDTH-1:32];
            `AW_BASE + `REG_LEN_ID  : tst_cfg_rdata <= 32'({aw_beat.id, aw_beat.len});

            // W control also reflects WLAST in bit 4
            `W_BASE + `REG_CTRL     : tst_cfg_rdata <= {27'd0, w_beat.last, 2'b00, w_done, w_valid};
            `W_BASE + `REG_W_INDEX  : tst_cfg_rdata <= 32'(w_index);
            `W_BASE + `REG_W_DATA   : tst_cfg_rdata <= w_index_word;
            `W_BASE + `REG_W_STRB   : tst_cfg_rdata <= 32'(w_beat.strb);

            `B_BASE + `REG_CTRL     : tst_cfg_rdata <= {28'd0, b_captured.resp, b_done, b_ready};
            `B_BASE + `REG_B_ID     : tst_cfg_rdata <= 32'(b_captured.id);

            `AR_BASE + `REG_CTRL    : tst_cfg_rdata <= {30'd0, ar_done, ar_valid};
            `AR_BASE + `REG_ADDR_LO : tst_cfg_rdata <= ar_beat.addr[31:0];
            `AR_BASE + `REG_ADDR_HI : tst_cfg_rdata <= ar_beat.addr[`AXI_ADDR_WIDTH-1:32];
            `AR_BASE + `REG_LEN_ID  : tst_cfg_rdata <= 32'({ar_beat.id, ar_beat.len});

            default                 : tst_cfg_rdata <= `CFG_UNIMPL_VALUE;
         endcase
      end
   end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_tst -f verilog.f -o tb_axi_tst \
   && ./obj_dir/tb_axi_tst | tee /dev/stderr | grep -qx '>>> PASS' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tb_axi_tst.sv
// Testbench for the AXI generator top, drives host register accesses and a random-ready AXI slave
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module tb_axi_tst;

   localparam int ACK_LIMIT  = 20;
   localparam int POLL_LIMIT = 40;

   logic                         clk;
   logic                         sync_rst_n;
   logic [31:0]                  cfg_addr;
   logic [31:0]                  cfg_wdata;
   logic                         cfg_wr;
   logic                         cfg_rd;
   logic                         tst_cfg_ack;
   logic [31:0]                  tst_cfg_rdata;
   logic [`AXI_ID_WIDTH-1:0]     awid;
   logic [`AXI_ADDR_WIDTH-1:0]   awaddr;
   logic [`AXI_LEN_WIDTH-1:0]    awlen;
   logic                         awvalid;
   logic                         awready;
   logic [`AXI_DATA_WIDTH-1:0]   wdata;
   logic [`AXI_DATA_WIDTH/8-1:0] wstrb;
   logic                         wlast;
   logic                         wvalid;
   logic                         wready;
   logic [`AXI_ID_WIDTH-1:0]     bid;
   logic [1:0]                   bresp;
   logic                         bvalid;
   logic                         bready;
   logic [`AXI_ID_WIDTH-1:0]     arid;
   logic [`AXI_ADDR_WIDTH-1:0]   araddr;
   logic [`AXI_LEN_WIDTH-1:0]    arlen;
   logic                         arvalid;
   logic                         arready;

   axi_tst_pkg::addr_beat_t      exp_aw;
   axi_tst_pkg::addr_beat_t      exp_ar;
   axi_tst_pkg::wdata_beat_t     exp_w;
   logic [31:0]                  read_data;
   logic [7:0]                   lfsr;
   logic                         aw_accepted;
   logic                         b_accepted;
   logic [`AXI_ID_WIDTH-1:0]     aw_accepted_id;
   int                           errors;
   int                           timeouts;

   axi_tst_top u_dut
   (
      .clk (clk), .sync_rst_n (sync_rst_n),
      .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata), .cfg_wr (cfg_wr), .cfg_rd (cfg_rd),
      .tst_cfg_ack (tst_cfg_ack), .tst_cfg_rdata (tst_cfg_rdata),
      .awid (awid), .awaddr (awaddr), .awlen (awlen), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
      .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .arid (arid), .araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready)
   );

   bind axi_tst_top axi_tst_assert u_assert
   (
      .clk (clk), .sync_rst_n (sync_rst_n), .cfg_wr (cfg_wr), .cfg_rd (cfg_rd),
      .tst_cfg_ack (tst_cfg_ack),
      .awid (awid), .awaddr (awaddr), .awlen (awlen), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
      .bvalid (bvalid), .bready (bready),
      .arid (arid), .araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready)
   );

   always #4 clk = ~clk;

   // 8-bit maximal Fibonacci LFSR, taps 8 6 5 4
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // One host command, then wait for its ack
   task automatic host_access(input logic write, input logic [7:0] ofs, input logic [31:0] data);
      int cycles;
      cycles    = 0;
      cfg_addr  = 32'(ofs);
      cfg_wdata = data;
      cfg_wr    = write;
      cfg_rd    = !write;
      @(posedge clk);
      #1;
      cfg_wr = 1'b0;
      cfg_rd = 1'b0;
      while (!tst_cfg_ack && cycles < ACK_LIMIT)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (tst_cfg_ack)
         read_data = tst_cfg_rdata;
      else
      begin
         timeouts++;
         $display("timeout at %0t: no ack for the access to offset 0x%02h", $time, ofs);
      end
   endtask

   task automatic reg_write(input logic [7:0] ofs, input logic [31:0] data);
      host_access(1'b1, ofs, data);
   endtask

   task automatic read_check(input string name, input logic [7:0] ofs, input logic [31:0] exp);
      host_access(1'b0, ofs, 32'h0);
      check_value(name, 128'(read_data), 128'(exp));
   endtask

   // Poll a control register until its done bit is set
   task automatic wait_done(input logic [7:0] ofs);
      int tries;
      tries = 0;
      host_access(1'b0, ofs, 32'h0);
      while (!read_data[`CTRL_CLR_BIT] && tries < POLL_LIMIT)
      begin
         host_access(1'b0, ofs, 32'h0);
         tries++;
      end
      if (!read_data[`CTRL_CLR_BIT])
      begin
         timeouts++;
         $display("timeout at %0t: done never set at offset 0x%02h", $time, ofs);
      end
   endtask

   task automatic run_addr_chan(input logic [7:0] base, input axi_tst_pkg::addr_beat_t b,
                                input string tag);
      reg_write(base + `REG_ADDR_LO, b.addr[31:0]);
      reg_write(base + `REG_ADDR_HI, b.addr[63:32]);
      reg_write(base + `REG_LEN_ID, 32'({b.id, b.len}));
      read_check({tag, " addr low"}, base + `REG_ADDR_LO, b.addr[31:0]);
      read_check({tag, " addr high"}, base + `REG_ADDR_HI, b.addr[63:32]);
      read_check({tag, " len/id"}, base + `REG_LEN_ID, 32'({b.id, b.len}));
      reg_write(base + `REG_CTRL, 32'h1);
      wait_done(base + `REG_CTRL);
      read_check({tag, " control"}, base + `REG_CTRL, 32'h2);
      reg_write(base + `REG_CTRL, 32'h2);
      read_check({tag, " control after clear"}, base + `REG_CTRL, 32'h0);
   endtask

   // Handshakes seen mid-cycle, beat contents checked there
   always @(negedge clk)
   begin
      aw_accepted = sync_rst_n && awvalid && awready;
      b_accepted  = sync_rst_n && bvalid && bready;
      if (aw_accepted)
      begin
         aw_accepted_id = awid;
         check_value("awaddr", 128'(awaddr), 128'(exp_aw.addr));
         check_value("awlen", 128'(awlen), 128'(exp_aw.len));
         check_value("awid", 128'(awid), 128'(exp_aw.id));
      end
      if (sync_rst_n && arvalid && arready)
      begin
         check_value("araddr", 128'(araddr), 128'(exp_ar.addr));
         check_value("arlen", 128'(arlen), 128'(exp_ar.len));
         check_value("arid", 128'(arid), 128'(exp_ar.id));
      end
      if (sync_rst_n && wvalid && wready)
      begin
         check_value("wdata", wdata, exp_w.data);
         check_value("wstrb", 128'(wstrb), 128'(exp_w.strb));
         check_value("wlast", 128'(wlast), 128'(exp_w.last));
      end
   end

   // Slave model, random readies and one B response per AW beat
   always @(posedge clk)
   begin
      #1;
      if (b_accepted)
         bvalid = 1'b0;
      if (aw_accepted)
      begin
         bvalid = 1'b1;
         bid    = aw_accepted_id;
      end
      lfsr    = lfsr_step(lfsr);
      awready = lfsr[0];
      lfsr    = lfsr_step(lfsr);
      wready  = lfsr[0];
      lfsr    = lfsr_step(lfsr);
      arready = lfsr[0];
   end

   initial
   begin
      clk         = 1'b0;
      sync_rst_n  = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      cfg_wr      = 1'b0;
      cfg_rd      = 1'b0;
      awready     = 1'b0;
      wready      = 1'b0;
      arready     = 1'b0;
      bvalid      = 1'b0;
      bid         = '0;
      bresp       = 2'(axi_tst_pkg::SLVERR);
      lfsr        = 8'd59;
      aw_accepted = 1'b0;
      b_accepted  = 1'b0;
      errors      = 0;
      timeouts    = 0;
      exp_aw      = '{addr: 64'h0000_00AB_1234_5678, len: 8'h07, id: 5'h13};
      exp_ar      = '{addr: 64'h0000_0001_9ABC_DEF0, len: 8'h03, id: 5'h0A};
      exp_w       = '{data: 128'hCAFE_0003_BEEF_0002_F00D_0001_ACE0_0000,
                      strb: 16'hF0F0, last: 1'b1};
      repeat (3) @(posedge clk);
      #1;
      sync_rst_n = 1'b1;

      // Bready waits here until the slave answers the AW beat
      reg_write(`B_BASE + `REG_CTRL, 32'h1);

      run_addr_chan(`AW_BASE, exp_aw, "aw");

      reg_write(`W_BASE + `REG_W_INDEX, 32'h0);
      for (int i = 0; i < `AXI_NUM_DW; i++)
         reg_write(`W_BASE + `REG_W_DATA, exp_w.data[32*i +: 32]);
      read_check("w index", `W_BASE + `REG_W_INDEX, 32'(`AXI_NUM_DW));
      read_check("w data past last word", `W_BASE + `REG_W_DATA, 32'h0);
      for (int i = 0; i < `AXI_NUM_DW; i++)
      begin
         reg_write(`W_BASE + `REG_W_INDEX, 32'(i));
         read_check("w data word", `W_BASE + `REG_W_DATA, exp_w.data[32*i +: 32]);
      end
      reg_write(`W_BASE + `REG_W_STRB, 32'(exp_w.strb));
      read_check("w strobe", `W_BASE + `REG_W_STRB, 32'(exp_w.strb));
      reg_write(`W_BASE + `REG_CTRL, 32'h11);
      wait_done(`W_BASE + `REG_CTRL);
      read_check("w control", `W_BASE + `REG_CTRL, 32'h12);
      reg_write(`W_BASE + `REG_CTRL, 32'h2);
      read_check("w control after clear", `W_BASE + `REG_CTRL, 32'h0);

      wait_done(`B_BASE + `REG_CTRL);
      read_check("b control", `B_BASE + `REG_CTRL, 32'({axi_tst_pkg::SLVERR, 2'b10}));
      read_check("b id", `B_BASE + `REG_B_ID, 32'(exp_aw.id));

      run_addr_chan(`AR_BASE, exp_ar, "ar");

      read_check("unimplemented offset 0x50", 8'h50, `CFG_UNIMPL_VALUE);
      read_check("unimplemented offset 0x7C", 8'h7C, `CFG_UNIMPL_VALUE);

      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+.
axi_tst_pkg.sv
cfg_port.sv
addr_chan_gen.sv
wdata_chan_gen.sv
bresp_capture.sv
cfg_readback.sv
axi_tst_top.sv
axi_tst_assert.sv
tb_axi_tst.sv

//--- wdata_chan_gen.sv
// AXI W channel, indexed data words with auto-increment, strobe, WLAST, valid and done
`timescale 1ns/10ps
`include "axi_tst_config.svh"

module wdata_chan_gen
(
   input  logic                        clk,
   input  logic                        sync_rst_n,
   input  axi_tst_pkg::cfg_req_t       cfg_req,
   output axi_tst_pkg::wdata_beat_t    beat,
   output logic                        valid,
   input  logic                        ready,
   output logic                        done,
   output logic [`CFG_INDEX_WIDTH-1:0] index,
   output logic [31:0]                 index_word
);

   logic ctrl_wr;
   logic index_wr;
   logic data_wr;
   logic strb_wr;
   logic handshake;

   assign ctrl_wr   = cfg_req.wr && (cfg_req.ofs == `W_BASE + `REG_CTRL);
   assign index_wr  = cfg_req.wr && (cfg_req.ofs == `W_BASE + `REG_W_INDEX);
   assign data_wr   = cfg_req.wr && (cfg_req.ofs == `W_BASE + `REG_W_DATA);
   assign strb_wr   = cfg_req.wr && (cfg_req.ofs == `W_BASE + `REG_W_STRB);
   assign handshake = valid && ready;

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         beat  <= '0;
         index <= '0;
      end
      else
      begin
         // Index past the last word writes nothing
         for (int i = 0; i < `AXI_NUM_DW; i++)
            if (data_wr && (index == `CFG_INDEX_WIDTH'(i)))
               beat.data[32*i +: 32] <= cfg_req.wdata;
         if (index_wr)
            index <= cfg_req.wdata[`CFG_INDEX_WIDTH-1:0];
         else if (data_wr)
            index <= index + 1'b1;
         if (strb_wr)
            beat.strb <= cfg_req.wdata[`AXI_DATA_WIDTH/8-1:0];
         if (ctrl_wr)
            beat.last <= cfg_req.wdata[`CTRL_WLAST_BIT];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         valid <= 1'b0;
         done  <= 1'b0;
      end
      else
      begin
         if (ctrl_wr && cfg_req.wdata[`CTRL_SET_BIT])
            valid <= 1'b1;
         else if (handshake)
            valid <= 1'b0;
         if (handshake)
            done <= 1'b1;
         else if (ctrl_wr && cfg_req.wdata[`CTRL_CLR_BIT])
            done <= 1'b0;
      end
   end

   // Word at the current index for readback, zero when out of range
   always_comb
   begin
      index_word = '0;
      for (int i = 0; i < `AXI_NUM_DW; i++)
         if (index == `CFG_INDEX_WIDTH'(i))
            index_word = beat.data[32*i +: 32];
   end

endmodule
